//--- src/mc1201_pkg.sv
/*
 * shared bus widths, device address map, grant encodings
 * and board constants for the mc1201 system bus fabric
 */
package mc1201_pkg;

   //**********************************************************************
   //* widths
   //**********************************************************************
   localparam int DEV_N = 5;              // decoded bus targets

   typedef logic [16:0]      adr_t;       // bit 16 marks the console (shadow) half
   typedef logic [15:0]      dma_adr_t;   // dma masters reach the low 64k only
   typedef logic [15:0]      word_t;
   typedef logic [1:0]       sel_t;       // high and low byte lanes
   typedef logic [DEV_N-1:0] dev_vec_t;   // one bit per decoded device

   // bit positions inside dev_vec_t
   localparam int DEV_ROM  = 0;
   localparam int DEV_DRAM = 1;
   localparam int DEV_TT   = 2;
   localparam int DEV_RK   = 3;
   localparam int DEV_MY   = 4;

   // bit positions of the sd card request vectors
   localparam int REQ_RK = 0;
   localparam int REQ_DW = 1;
   localparam int REQ_DX = 2;
   localparam int REQ_MY = 3;

   //**********************************************************************
   //* i/o page map
   //**********************************************************************
   localparam adr_t TT_BASE = 17'o177560;    // 8 bytes of console port
   localparam adr_t RK_BASE = 17'o177400;    // 16 bytes of rk disk registers
   localparam adr_t MY_BASE = 17'o172140;    // 4 bytes of my floppy registers

   localparam int unsigned TT_SHIFT = 3;     // low bits ignored per device
   localparam int unsigned RK_SHIFT = 4;
   localparam int unsigned MY_SHIFT = 2;

   localparam logic [3:0] ROM_TAG     = 4'b1110;  // shadow rom at 140000 of console half
   localparam logic [2:0] IO_PAGE_TAG = 3'b111;   // top 8k that bit 16 flips for dram

   //**********************************************************************
   //* board
   //**********************************************************************
   localparam int SLOW_DIV = 22;                  // cpu slow-down period in clocks
   localparam int SLOW_W   = $clog2(SLOW_DIV);

   // bus owner
   typedef enum logic [1:0] {
      GNT_CPU,
      GNT_RK,
      GNT_MY
   } grant_e;

   // sd card owner
   typedef enum logic [2:0] {
      SD_IDLE,
      SD_RK,
      SD_DW,
      SD_DX,
      SD_MY
   } sd_owner_e;

endpackage

//--- src/wb_bus_if.sv
/*
 * shared wishbone bus between the master switch and the
 * i/o page decoder, with master and slave modports
 */
`timescale 1ns/1ps

interface wb_bus_if;
   import mc1201_pkg::*;

   adr_t  adr;     // 17 bit address with the console half on top
   word_t dat_w;   // write data from the owner
   word_t dat_r;   // read data from the strobed device
   logic  cyc;     // cycle in progress
   logic  we;      // 1 = write
   sel_t  sel;     // byte select
   logic  stb;     // data strobe
   logic  ack;     // device acknowledge

   // bus owner side
   modport master (
      output adr, dat_w, cyc, we, sel, stb,
      input  dat_r, ack
   );

   // device side
   modport slave (
      input  adr, dat_w, cyc, we, sel, stb,
      output dat_r, ack
   );

endinterface

//--- src/bus_master_switch.sv
/*
 * dma arbiter and bus master switch
 * hands the shared bus to the cpu or to the rk / my dma controllers
 */
`timescale 1ns/1ps

module bus_master_switch (
   input  logic                 wb_clk,
   input  logic                 rst_n_i,
   // cpu master
   input  mc1201_pkg::adr_t     cpu_adr_i,
   input  mc1201_pkg::word_t    cpu_dat_i,
   input  logic                 cpu_cyc_i,
   input  logic                 cpu_we_i,
   input  mc1201_pkg::sel_t     cpu_sel_i,
   input  logic                 cpu_stb_i,
   output logic                 cpu_ack_o,
   output logic                 cpu_gnt_o,
   // rk dma master
   input  logic                 rk_dma_req_i,
   input  mc1201_pkg::dma_adr_t rk_dma_adr_i,
   input  mc1201_pkg::word_t    rk_dma_dat_i,
   input  logic                 rk_dma_we_i,
   input  logic                 rk_dma_stb_i,
   output logic                 rk_dma_gnt_o,
   output logic                 rk_dma_ack_o,
   // my dma master
   input  logic                 my_dma_req_i,
   input  mc1201_pkg::dma_adr_t my_dma_adr_i,
   input  mc1201_pkg::word_t    my_dma_dat_i,
   input  logic                 my_dma_we_i,
   input  logic                 my_dma_stb_i,
   output logic                 my_dma_gnt_o,
   output logic                 my_dma_ack_o,
   // shared bus
   wb_bus_if.master             bus
);
   import mc1201_pkg::*;

   grant_e gnt_q;   // current bus owner
   logic   is_rk;
   logic   is_my;

   //**********************************************************************
   //* arbiter
   //**********************************************************************
   // owner changes only between bus cycles
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         gnt_q <= GNT_CPU;
      end else if (!bus.cyc) begin
         if (rk_dma_req_i) begin
            gnt_q <= GNT_RK;       // rk wins over my
         end else if (my_dma_req_i) begin
            gnt_q <= GNT_MY;
         end else begin
            gnt_q <= GNT_CPU;      // no dma pending
         end
      end
   end

   assign is_rk = (gnt_q == GNT_RK);
   assign is_my = (gnt_q == GNT_MY);

   assign cpu_gnt_o    = (gnt_q == GNT_CPU);  // cpu stalls on ack while low
   assign rk_dma_gnt_o = is_rk;
   assign my_dma_gnt_o = is_my;

   //**********************************************************************
   //* master multiplexer
   //**********************************************************************
   assign bus.adr   = is_rk ? adr_t'(rk_dma_adr_i) :   // dma address zero-extended
                      is_my ? adr_t'(my_dma_adr_i) : cpu_adr_i;
   assign bus.dat_w = is_rk ? rk_dma_dat_i : is_my ? my_dma_dat_i : cpu_dat_i;
   assign bus.cyc   = is_rk ? rk_dma_req_i : is_my ? my_dma_req_i : cpu_cyc_i; // req frames the cycle
   assign bus.we    = is_rk ? rk_dma_we_i  : is_my ? my_dma_we_i  : cpu_we_i;
   assign bus.sel   = (is_rk | is_my) ? 2'b11 : cpu_sel_i;   // dma moves whole words
   assign bus.stb   = is_rk ? rk_dma_stb_i : is_my ? my_dma_stb_i : cpu_stb_i;

   // ack goes back to the owner only
   assign cpu_ack_o    = cpu_gnt_o & bus.ack;
   assign rk_dma_ack_o = is_rk & bus.ack;
   assign my_dma_ack_o = is_my & bus.ack;

endmodule

//--- src/io_page_decoder.sv
/*
 * address decoder for the shared bus
 * device strobes, acknowledge or and read data multiplexer
 */
`timescale 1ns/1ps

module io_page_decoder (
   wb_bus_if.slave              bus,
   output mc1201_pkg::dev_vec_t dev_stb_o,   // one strobe per device
   input  mc1201_pkg::dev_vec_t dev_ack_i,
   input  mc1201_pkg::word_t    rom_dat_i,
   input  mc1201_pkg::word_t    dram_dat_i,
   input  mc1201_pkg::word_t    tt_dat_i,
   input  mc1201_pkg::word_t    rk_dat_i,
   input  mc1201_pkg::word_t    my_dat_i
);
   import mc1201_pkg::*;

   logic  bus_act;              // stb and cyc together
   word_t dev_dat [DEV_N];      // read data by device index
   word_t rd_mux;

   // register window match ignoring the low address bits
   function automatic logic io_hit(adr_t adr, adr_t base, int unsigned sh);
      return (adr >> sh) == (base >> sh);
   endfunction

   assign bus_act = bus.stb & bus.cyc;

   //**********************************************************************
   //* strobes
   //**********************************************************************
   // monitor rom in the shadow area
   assign dev_stb_o[DEV_ROM]  = bus_act & (bus.adr[16:13] == ROM_TAG);
   // user half below the i/o page, console half only inside it
   assign dev_stb_o[DEV_DRAM] = bus_act & ((bus.adr[15:13] != IO_PAGE_TAG) ^ bus.adr[16]);
   assign dev_stb_o[DEV_TT]   = bus_act & io_hit(bus.adr, TT_BASE, TT_SHIFT); // 177560..177566
   assign dev_stb_o[DEV_RK]   = bus_act & io_hit(bus.adr, RK_BASE, RK_SHIFT); // 177400..177416
   assign dev_stb_o[DEV_MY]   = bus_act & io_hit(bus.adr, MY_BASE, MY_SHIFT); // 172140..172142

   //**********************************************************************
   //* acknowledge and read data
   //**********************************************************************
   assign bus.ack = |dev_ack_i;   // devices answer only when strobed

   assign dev_dat[DEV_ROM]  = rom_dat_i;
   assign dev_dat[DEV_DRAM] = dram_dat_i;
   assign dev_dat[DEV_TT]   = tt_dat_i;
   assign dev_dat[DEV_RK]   = rk_dat_i;
   assign dev_dat[DEV_MY]   = my_dat_i;

   // or of all strobed sources
   always_comb begin
      rd_mux = '0;
      for (int i = 0; i < DEV_N; i++) begin
         if (dev_stb_o[i]) begin
            rd_mux = rd_mux | dev_dat[i];
         end
      end
   end

   assign bus.dat_r = rd_mux;   // zero when nothing is selected

endmodule

//--- src/sd_card_dispatcher.sv
/*
 * sd card access dispatcher
 * one card shared by rk, dw, dx and my in fixed priority
 */
`timescale 1ns/1ps

module sd_card_dispatcher (
   input  logic       wb_clk,
   input  logic       rst_n_i,
   input  logic [3:0] sd_req_i,    // rk, dw, dx, my from bit 0
   output logic [3:0] sd_ack_o,
   input  logic [3:0] sd_mosi_i,
   input  logic [3:0] sd_cs_i,
   output logic       sdcard_mosi_o,
   output logic       sdcard_cs_o
);
   import mc1201_pkg::*;

   sd_owner_e owner_q;
   logic      own_req;   // request line of the current owner

   always_comb begin
      case (owner_q)
         SD_RK:   own_req = sd_req_i[REQ_RK];
         SD_DW:   own_req = sd_req_i[REQ_DW];
         SD_DX:   own_req = sd_req_i[REQ_DX];
         SD_MY:   own_req = sd_req_i[REQ_MY];
         default: own_req = 1'b0;
      endcase
   end

   //**********************************************************************
   //* grant state
   //**********************************************************************
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         owner_q <= SD_IDLE;
      end else if (owner_q == SD_IDLE) begin
         // card free, pick the first requester
         if (sd_req_i[REQ_RK])      owner_q <= SD_RK;
         else if (sd_req_i[REQ_DW]) owner_q <= SD_DW;
         else if (sd_req_i[REQ_DX]) owner_q <= SD_DX;
         else if (sd_req_i[REQ_MY]) owner_q <= SD_MY;
      end else if (!own_req) begin
         owner_q <= SD_IDLE;   // released, next grant one cycle later
      end
   end

   assign sd_ack_o[REQ_RK] = (owner_q == SD_RK);
   assign sd_ack_o[REQ_DW] = (owner_q == SD_DW);
   assign sd_ack_o[REQ_DX] = (owner_q == SD_DX);
   assign sd_ack_o[REQ_MY] = (owner_q == SD_MY);

   //**********************************************************************
   //* card line routing
   //**********************************************************************
   always_comb begin
      case (owner_q)
         SD_DW: begin
            sdcard_mosi_o = sd_mosi_i[REQ_DW];
            sdcard_cs_o   = sd_cs_i[REQ_DW];
         end
         SD_DX: begin
            sdcard_mosi_o = sd_mosi_i[REQ_DX];
            sdcard_cs_o   = sd_cs_i[REQ_DX];
         end
         SD_MY: begin
            sdcard_mosi_o = sd_mosi_i[REQ_MY];
            sdcard_cs_o   = sd_cs_i[REQ_MY];
         end
         SD_RK: begin
            sdcard_mosi_o = sd_mosi_i[REQ_RK];
            sdcard_cs_o   = sd_cs_i[REQ_RK];
         end
         default: begin
            sdcard_mosi_o = 1'b1;   // idle line, card deselected
            sdcard_cs_o   = 1'b1;
         end
      endcase
   end

endmodule

//--- src/board_ctrl.sv
/*
 * board control
 * timer button debounce and enable, timer irq gate,
 * cpu slow-down enable and indicator leds
 */
`timescale 1ns/1ps

module board_ctrl (
   input  logic       wb_clk,
   input  logic       rst_n_i,
   input  logic       tick_50hz_i,    // one clock pulse at 50 hz
   input  logic       timer_btn_i,    // 1 = pressed
   input  logic       cpu_slow_i,
   input  logic [3:0] sd_req_i,       // rk, dw, dx, my from bit 0
   output logic       timer_irq_o,
   output logic       cpu_clk_ena_o,
   output logic [3:0] led_o           // active low
);
   import mc1201_pkg::*;

   logic [1:0]        btn_sh;   // button samples taken one per tick
   logic              lock;     // toggle done for this press
   logic              timer_on;
   logic [SLOW_W-1:0] slow_cnt;
   logic              slow_pulse;

   //**********************************************************************
   //* timer button
   //**********************************************************************
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         btn_sh   <= '0;
         lock     <= 1'b0;
         timer_on <= 1'b1;   // timer runs after reset
      end else if (tick_50hz_i) begin
         btn_sh <= {btn_sh[0], timer_btn_i};
         if (&btn_sh) begin
            if (!lock) begin
               timer_on <= ~timer_on;   // stable press
            end
            lock <= 1'b1;
         end else if (~|btn_sh) begin
            lock <= 1'b0;               // stable release re-arms
         end
      end
   end

   assign timer_irq_o = tick_50hz_i & timer_on;

   //**********************************************************************
   //* slow-down counter
   //**********************************************************************
   always_ff @(posedge wb_clk) begin
      if (!rst_n_i) begin
         slow_cnt <= '0;
      end else if (slow_cnt == SLOW_W'(SLOW_DIV - 1)) begin
         slow_cnt <= '0;
      end else begin
         slow_cnt <= slow_cnt + 1'b1;
      end
   end

   assign slow_pulse    = (slow_cnt == '0);   // one clock in SLOW_DIV
   assign cpu_clk_ena_o = cpu_slow_i ? slow_pulse : 1'b1;

   // leds
   assign led_o[0] = ~sd_req_i[REQ_RK];
   assign led_o[1] = ~sd_req_i[REQ_DW];
   assign led_o[2] = ~(sd_req_i[REQ_MY] | sd_req_i[REQ_DX]);   // shared floppy lamp
   assign led_o[3] = ~timer_on;

endmodule

//--- src/mc1201_fabric.sv
/*
 * mc1201 system bus fabric top level
 * master switch, i/o page decoder, sd dispatcher, board control
 */
`timescale 1ns/1ps

module mc1201_fabric (
   input  logic                 wb_clk,
   input  logic                 rst_n_i,
   input  logic                 tick_50hz_i,
   // cpu
   input  mc1201_pkg::adr_t     cpu_adr_i,
   input  mc1201_pkg::word_t    cpu_dat_i,
   output mc1201_pkg::word_t    cpu_dat_o,      // bus read data that also feeds dma
   input  logic                 cpu_cyc_i,
   input  logic                 cpu_we_i,
   input  mc1201_pkg::sel_t     cpu_sel_i,
   input  logic                 cpu_stb_i,
   output logic                 cpu_ack_o,
   output logic                 cpu_gnt_o,
   // rk dma
   input  logic                 rk_dma_req_i,
   input  mc1201_pkg::dma_adr_t rk_dma_adr_i,
   input  mc1201_pkg::word_t    rk_dma_dat_i,
   input  logic                 rk_dma_we_i,
   input  logic                 rk_dma_stb_i,
   output logic                 rk_dma_gnt_o,
   output logic                 rk_dma_ack_o,
   // my dma
   input  logic                 my_dma_req_i,
   input  mc1201_pkg::dma_adr_t my_dma_adr_i,
   input  mc1201_pkg::word_t    my_dma_dat_i,
   input  logic                 my_dma_we_i,
   input  logic                 my_dma_stb_i,
   output logic                 my_dma_gnt_o,
   output logic                 my_dma_ack_o,
   // devices
   output mc1201_pkg::dev_vec_t dev_stb_o,
   input  mc1201_pkg::dev_vec_t dev_ack_i,
   input  mc1201_pkg::word_t    rom_dat_i,
   input  mc1201_pkg::word_t    dram_dat_i,
   input  mc1201_pkg::word_t    tt_dat_i,
   input  mc1201_pkg::word_t    rk_dat_i,
   input  mc1201_pkg::word_t    my_dat_i,
   // sd card
   input  logic [3:0]           sd_req_i,
   output logic [3:0]           sd_ack_o,
   input  logic [3:0]           sd_mosi_i,
   input  logic [3:0]           sd_cs_i,
   output logic                 sdcard_mosi_o,
   output logic                 sdcard_cs_o,
   // board
   input  logic                 timer_btn_i,
   input  logic                 cpu_slow_i,
   output logic                 timer_irq_o,
   output logic                 cpu_clk_ena_o,
   output logic [3:0]           led_o
);

   wb_bus_if bus ();   // shared bus

   assign cpu_dat_o = bus.dat_r;

   //**********************************************************************
   //* bus fabric
   //**********************************************************************
   bus_master_switch u_switch (
      .wb_clk       (wb_clk),
      .rst_n_i      (rst_n_i),
      .cpu_adr_i    (cpu_adr_i),
      .cpu_dat_i    (cpu_dat_i),
      .cpu_cyc_i    (cpu_cyc_i),
      .cpu_we_i     (cpu_we_i),
      .cpu_sel_i    (cpu_sel_i),
      .cpu_stb_i    (cpu_stb_i),
      .cpu_ack_o    (cpu_ack_o),
      .cpu_gnt_o    (cpu_gnt_o),
      .rk_dma_req_i (rk_dma_req_i),
      .rk_dma_adr_i (rk_dma_adr_i),
      .rk_dma_dat_i (rk_dma_dat_i),
      .rk_dma_we_i  (rk_dma_we_i),
      .rk_dma_stb_i (rk_dma_stb_i),
      .rk_dma_gnt_o (rk_dma_gnt_o),
      .rk_dma_ack_o (rk_dma_ack_o),
      .my_dma_req_i (my_dma_req_i),
      .my_dma_adr_i (my_dma_adr_i),
      .my_dma_dat_i (my_dma_dat_i),
      .my_dma_we_i  (my_dma_we_i),
      .my_dma_stb_i (my_dma_stb_i),
      .my_dma_gnt_o (my_dma_gnt_o),
      .my_dma_ack_o (my_dma_ack_o),
      .bus          (bus.master)
   );

   io_page_decoder u_decoder (
      .bus        (bus.slave),
      .dev_stb_o  (dev_stb_o),
      .dev_ack_i  (dev_ack_i),
      .rom_dat_i  (rom_dat_i),
      .dram_dat_i (dram_dat_i),
      .tt_dat_i   (tt_dat_i),
      .rk_dat_i   (rk_dat_i),
      .my_dat_i   (my_dat_i)
   );

   //**********************************************************************
   //* sd card and board
   //**********************************************************************
   sd_card_dispatcher u_sd_disp (
      .wb_clk        (wb_clk),
      .rst_n_i       (rst_n_i),
      .sd_req_i      (sd_req_i),
      .sd_ack_o      (sd_ack_o),
      .sd_mosi_i     (sd_mosi_i),
      .sd_cs_i       (sd_cs_i),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_cs_o   (sdcard_cs_o)
   );

   board_ctrl u_board (
      .wb_clk        (wb_clk),
      .rst_n_i       (rst_n_i),
      .tick_50hz_i   (tick_50hz_i),
      .timer_btn_i   (timer_btn_i),
      .cpu_slow_i    (cpu_slow_i),
      .sd_req_i      (sd_req_i),    // same requests light the disk leds
      .timer_irq_o   (timer_irq_o),
      .cpu_clk_ena_o (cpu_clk_ena_o),
      .led_o         (led_o)
   );

endmodule

//--- tb/tb_model.svh
/*
 * reference model for the bus fabric testbench
 * address decode, bus arbitration, sd dispatch,
 * timer button toggle and slow-down counter
 */

// model owner codes
localparam int         OWN_CPU  = 0;
localparam int         OWN_RK   = 1;
localparam int         OWN_MY   = 2;
localparam logic [2:0] SD_NONE  = 3'd4;   // 0..3 = rk, dw, dx, my
localparam int         SLOW_LEN = 22;     // slow-down period in clocks

int         m_gnt;        // bus owner
logic [2:0] m_sd;         // sd card owner
logic       m_timer_on;
logic [1:0] m_btn;        // button samples
logic       m_lock;
int         m_slow;       // slow-down phase

// address inside a register window of 2**sh bytes
function automatic logic in_window(logic [16:0] adr, logic [16:0] base, int unsigned sh);
   return (adr >= base) && (adr < base + (17'd1 << sh));
endfunction

// strobes ordered rom, dram, tt, rk, my
function automatic logic [4:0] expected_strobes(logic [16:0] adr, logic act);
   logic [4:0] s;
   s[0] = (adr[16:13] == 4'b1110);                                    // shadow rom
   s[1] = adr[16] ? (adr[15:13] == 3'b111) : (adr[15:13] != 3'b111);  // dram
   s[2] = in_window(adr, mc1201_pkg::TT_BASE, mc1201_pkg::TT_SHIFT);
   s[3] = in_window(adr, mc1201_pkg::RK_BASE, mc1201_pkg::RK_SHIFT);
   s[4] = in_window(adr, mc1201_pkg::MY_BASE, mc1201_pkg::MY_SHIFT);
   return act ? s : 5'b00000;
endfunction

// cyc of the current owner
function automatic logic owner_cyc();
   if (m_gnt == OWN_RK) return rk_dma_req_i;
   if (m_gnt == OWN_MY) return my_dma_req_i;
   return cpu_cyc_i;
endfunction

// stb and address that the owner puts on the bus
task automatic bus_expect(output logic stb, output logic [16:0] adr);
   case (m_gnt)
      OWN_RK: begin
         stb = rk_dma_stb_i;
         adr = {1'b0, rk_dma_adr_i};   // dma reaches the low half only
      end
      OWN_MY: begin
         stb = my_dma_stb_i;
         adr = {1'b0, my_dma_adr_i};
      end
      default: begin
         stb = cpu_stb_i;
         adr = cpu_adr_i;
      end
   endcase
endtask

task automatic reset_model();
   m_gnt      = OWN_CPU;
   m_sd       = SD_NONE;
   m_timer_on = 1'b1;   // timer enabled out of reset
   m_btn      = 2'b00;
   m_lock     = 1'b0;
   m_slow     = 0;
endtask

// one rising edge of wb_clk
task automatic advance_model();
   // arbiter moves only between bus cycles and prefers rk
   if (!owner_cyc()) begin
      if (rk_dma_req_i) m_gnt = OWN_RK;
      else if (my_dma_req_i) m_gnt = OWN_MY;
      else m_gnt = OWN_CPU;
   end
   // sd card grant and release
   if (m_sd == SD_NONE) begin
      for (int i = 3; i >= 0; i--) begin
         if (sd_req_i[i]) m_sd = 3'(i);   // lowest index wins
      end
   end else if (!sd_req_i[m_sd[1:0]]) begin
      m_sd = SD_NONE;
   end
   // button debounce on the tick
   if (tick_50hz_i) begin
      if (m_btn == 2'b11) begin
         if (!m_lock) m_timer_on = !m_timer_on;
         m_lock = 1'b1;
      end else if (m_btn == 2'b00) begin
         m_lock = 1'b0;
      end
      m_btn = {m_btn[0], timer_btn_i};
   end
   m_slow = (m_slow == SLOW_LEN - 1) ? 0 : m_slow + 1;
endtask

//--- tb/tb_mc1201_fabric.sv
/*
 * testbench for the mc1201 bus fabric
 * clock, reset, xorshift stimulus, device responders,
 * checks against the reference model, watchdog and summary
 */
`timescale 1ns/1ps

module tb_mc1201_fabric;

   localparam int          CLK_PERIOD = 100;   // ns
   localparam int          RST_CYCLES = 5;
   localparam int          N_CYCLES   = 4000;
   localparam int          MARGIN     = 100;
   localparam logic [31:0] SEED       = 32'd32;

   logic        wb_clk = 1'b0;
   logic        rst_n_i;
   logic        tick_50hz_i;
   // cpu
   logic [16:0] cpu_adr_i;
   logic [15:0] cpu_dat_i;
   logic [15:0] cpu_dat_o;
   logic        cpu_cyc_i;
   logic        cpu_we_i;
   logic [1:0]  cpu_sel_i;
   logic        cpu_stb_i;
   logic        cpu_ack_o;
   logic        cpu_gnt_o;
   // rk dma
   logic        rk_dma_req_i;
   logic [15:0] rk_dma_adr_i;
   logic [15:0] rk_dma_dat_i;
   logic        rk_dma_we_i;
   logic        rk_dma_stb_i;
   logic        rk_dma_gnt_o;
   logic        rk_dma_ack_o;
   // my dma
   logic        my_dma_req_i;
   logic [15:0] my_dma_adr_i;
   logic [15:0] my_dma_dat_i;
   logic        my_dma_we_i;
   logic        my_dma_stb_i;
   logic        my_dma_gnt_o;
   logic        my_dma_ack_o;
   // devices
   logic [4:0]  dev_stb_o;
   logic [4:0]  dev_ack_i;
   logic [15:0] rom_dat_i;
   logic [15:0] dram_dat_i;
   logic [15:0] tt_dat_i;
   logic [15:0] rk_dat_i;
   logic [15:0] my_dat_i;
   // sd card
   logic [3:0]  sd_req_i;
   logic [3:0]  sd_ack_o;
   logic [3:0]  sd_mosi_i;
   logic [3:0]  sd_cs_i;
   logic        sdcard_mosi_o;
   logic        sdcard_cs_o;
   // board
   logic        timer_btn_i;
   logic        cpu_slow_i;
   logic        timer_irq_o;
   logic        cpu_clk_ena_o;
   logic [3:0]  led_o;

   logic [31:0] rng = SEED;
   logic [15:0] dev_dat [5];   // responder data per device
   logic [4:0]  ack_en;        // which devices answer this cycle
   int          btn_left;      // ticks until the button flips
   logic        hold_cyc;      // bus cyc seen at the coming edge
   logic [2:0]  hold_gnt;      // rk, my, cpu grants before that edge
   int          n_checks;
   int          n_err;

   `include "tb_model.svh"

   mc1201_fabric u_dut (.*);

   always #(CLK_PERIOD / 2) wb_clk = ~wb_clk;

   // model follows the rising edge
   always @(posedge wb_clk) begin
      if (!rst_n_i) reset_model();
      else advance_model();
   end

   //**********************************************************************
   //* device responders
   //**********************************************************************
   assign dev_ack_i  = dev_stb_o & ack_en;                    // strobed devices only
   assign rom_dat_i  = dev_stb_o[0] ? dev_dat[0] : 16'hffff;  // idle sources read high
   assign dram_dat_i = dev_stb_o[1] ? dev_dat[1] : 16'hffff;
   assign tt_dat_i   = dev_stb_o[2] ? dev_dat[2] : 16'hffff;
   assign rk_dat_i   = dev_stb_o[3] ? dev_dat[3] : 16'hffff;
   assign my_dat_i   = dev_stb_o[4] ? dev_dat[4] : 16'hffff;

   //**********************************************************************
   //* helpers
   //**********************************************************************
   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // bias toward device windows and their edges
   function automatic logic [16:0] pick_address(logic [31:0] r);
      case (r[18:16])
         3'd0:    return mc1201_pkg::TT_BASE + 17'(r[3:0]);
         3'd1:    return mc1201_pkg::RK_BASE + 17'(r[4:0]);
         3'd2:    return mc1201_pkg::MY_BASE + 17'(r[2:0]);
         3'd3:    return {4'b1110, r[12:0]};   // shadow rom area
         default: return r[16:0];
      endcase
   endfunction

   task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      n_err++;
   endtask

   task automatic check_reset_state();
      if (cpu_gnt_o !== 1'b1) report_value("cpu_gnt_o", 32'(cpu_gnt_o), 32'd1);
      if (rk_dma_gnt_o !== 1'b0) report_value("rk_dma_gnt_o", 32'(rk_dma_gnt_o), 32'd0);
      if (my_dma_gnt_o !== 1'b0) report_value("my_dma_gnt_o", 32'(my_dma_gnt_o), 32'd0);
      if (sd_ack_o !== 4'b0000) report_value("sd_ack_o", 32'(sd_ack_o), 32'd0);
      if (led_o[3] !== 1'b0) report_value("led_o[3]", 32'(led_o[3]), 32'd0);
      hold_gnt = {rk_dma_gnt_o, my_dma_gnt_o, cpu_gnt_o};
   endtask

   task automatic check_outputs();
      logic        stb;
      logic [16:0] adr;
      logic [4:0]  stb_exp;
      logic [15:0] dat_exp;
      logic        ack_exp;
      logic [3:0]  sd_exp;
      logic        mosi_exp;
      logic        cs_exp;
      logic [3:0]  led_exp;
      logic        ena_exp;
      bus_expect(stb, adr);
      stb_exp = expected_strobes(adr, owner_cyc() & stb);
      dat_exp = 16'h0000;
      for (int i = 0; i < 5; i++) begin
         if (stb_exp[i]) dat_exp = dat_exp | dev_dat[i];
      end
      ack_exp = |(stb_exp & ack_en);
      n_checks++;
      // decode and read data
      if (dev_stb_o !== stb_exp) report_value("dev_stb_o", 32'(dev_stb_o), 32'(stb_exp));
      if (cpu_dat_o !== dat_exp) report_value("cpu_dat_o", 32'(cpu_dat_o), 32'(dat_exp));
      // grants and routed acks
      if (cpu_gnt_o !== (m_gnt == OWN_CPU))
         report_value("cpu_gnt_o", 32'(cpu_gnt_o), 32'(m_gnt == OWN_CPU));
      if (rk_dma_gnt_o !== (m_gnt == OWN_RK))
         report_value("rk_dma_gnt_o", 32'(rk_dma_gnt_o), 32'(m_gnt == OWN_RK));
      if (my_dma_gnt_o !== (m_gnt == OWN_MY))
         report_value("my_dma_gnt_o", 32'(my_dma_gnt_o), 32'(m_gnt == OWN_MY));
      if (cpu_ack_o !== ((m_gnt == OWN_CPU) && ack_exp))
         report_value("cpu_ack_o", 32'(cpu_ack_o), 32'((m_gnt == OWN_CPU) && ack_exp));
      if (rk_dma_ack_o !== ((m_gnt == OWN_RK) && ack_exp))
         report_value("rk_dma_ack_o", 32'(rk_dma_ack_o), 32'((m_gnt == OWN_RK) && ack_exp));
      if (my_dma_ack_o !== ((m_gnt == OWN_MY) && ack_exp))
         report_value("my_dma_ack_o", 32'(my_dma_ack_o), 32'((m_gnt == OWN_MY) && ack_exp));
      if (hold_cyc && ({rk_dma_gnt_o, my_dma_gnt_o, cpu_gnt_o} !== hold_gnt)) begin
         $display("ERROR t=%0t bus grant moved while a bus cycle was active", $time);
         n_err++;
      end
      hold_gnt = {rk_dma_gnt_o, my_dma_gnt_o, cpu_gnt_o};
      // sd card
      sd_exp   = 4'b0000;
      mosi_exp = 1'b1;   // idle card lines
      cs_exp   = 1'b1;
      if (m_sd != SD_NONE) begin
         sd_exp   = 4'b0001 << m_sd[1:0];
         mosi_exp = sd_mosi_i[m_sd[1:0]];
         cs_exp   = sd_cs_i[m_sd[1:0]];
      end
      if ($countones(sd_ack_o) > 1) begin
         $display("ERROR t=%0t more than one sd controller holds the card", $time);
         n_err++;
      end
      if (sd_ack_o !== sd_exp) report_value("sd_ack_o", 32'(sd_ack_o), 32'(sd_exp));
      if (sdcard_mosi_o !== mosi_exp)
         report_value("sdcard_mosi_o", 32'(sdcard_mosi_o), 32'(mosi_exp));
      if (sdcard_cs_o !== cs_exp) report_value("sdcard_cs_o", 32'(sdcard_cs_o), 32'(cs_exp));
      // board
      led_exp = {~m_timer_on, ~(sd_req_i[3] | sd_req_i[2]), ~sd_req_i[1], ~sd_req_i[0]};
      ena_exp = cpu_slow_i ? (m_slow == 0) : 1'b1;
      if (led_o !== led_exp) report_value("led_o", 32'(led_o), 32'(led_exp));
      if (timer_irq_o !== (tick_50hz_i & m_timer_on))
         report_value("timer_irq_o", 32'(timer_irq_o), 32'(tick_50hz_i & m_timer_on));
      if (cpu_clk_ena_o !== ena_exp)
         report_value("cpu_clk_ena_o", 32'(cpu_clk_ena_o), 32'(ena_exp));
   endtask

   // new inputs after the falling edge
   task automatic drive_inputs();
      logic [31:0] r;
      logic [31:0] s;
      logic [16:0] a;
      r = next_random();
      s = next_random();
      // master requests and cycles held for several clocks
      if (r[2:0] == 3'd0) rk_dma_req_i = ~rk_dma_req_i;
      if (r[5:3] == 3'd0) my_dma_req_i = ~my_dma_req_i;
      if (r[7:6] == 2'd0) cpu_cyc_i = ~cpu_cyc_i;
      cpu_stb_i    = cpu_cyc_i & r[8];
      rk_dma_stb_i = r[9];
      my_dma_stb_i = r[10];
      cpu_we_i     = r[11];
      rk_dma_we_i  = r[12];
      my_dma_we_i  = r[13];
      cpu_sel_i    = r[15:14];
      cpu_dat_i    = s[15:0];
      rk_dma_dat_i = s[31:16];
      my_dma_dat_i = s[15:0] ^ s[31:16];
      cpu_adr_i    = pick_address(next_random());
      a            = pick_address(next_random());
      rk_dma_adr_i = a[15:0];
      a            = pick_address(next_random());
      my_dma_adr_i = a[15:0];
      // device data and acks
      for (int i = 0; i < 5; i++) begin
         s          = next_random();
         dev_dat[i] = s[15:0];
      end
      ack_en = s[20:16];
      // each sd request line changes about once in 16 clocks
      s = next_random();
      for (int i = 0; i < 4; i++) begin
         if (s[4*i +: 4] == 4'd0) sd_req_i[i] = ~sd_req_i[i];
      end
      sd_mosi_i = s[19:16];
      sd_cs_i   = s[23:20];
      // board inputs
      tick_50hz_i = (r[17:16] == 2'd0);
      if (r[23:18] == 6'd0) cpu_slow_i = ~cpu_slow_i;
      if (tick_50hz_i) begin
         btn_left--;
         if (btn_left <= 0) begin
            timer_btn_i = ~timer_btn_i;
            btn_left    = 1 + int'(r[26:24]);   // hold 1..8 ticks
         end
      end
      hold_cyc = owner_cyc();
   endtask

   //**********************************************************************
   //* main sequence
   //**********************************************************************
   initial begin
      n_checks     = 0;
      n_err        = 0;
      rst_n_i      = 1'b0;
      tick_50hz_i  = 1'b0;
      cpu_adr_i    = '0;
      cpu_dat_i    = '0;
      cpu_cyc_i    = 1'b0;
      cpu_we_i     = 1'b0;
      cpu_sel_i    = 2'b11;
      cpu_stb_i    = 1'b0;
      rk_dma_req_i = 1'b0;
      rk_dma_adr_i = '0;
      rk_dma_dat_i = '0;
      rk_dma_we_i  = 1'b0;
      rk_dma_stb_i = 1'b0;
      my_dma_req_i = 1'b0;
      my_dma_adr_i = '0;
      my_dma_dat_i = '0;
      my_dma_we_i  = 1'b0;
      my_dma_stb_i = 1'b0;
      sd_req_i     = 4'b0000;
      sd_mosi_i    = 4'b1111;
      sd_cs_i      = 4'b1111;
      timer_btn_i  = 1'b0;
      cpu_slow_i   = 1'b0;
      ack_en       = 5'b00000;
      btn_left     = 1;
      hold_cyc     = 1'b0;
      hold_gnt     = 3'b001;
      for (int i = 0; i < 5; i++) begin
         dev_dat[i] = 16'h0000;
      end
      repeat (RST_CYCLES) @(negedge wb_clk);
      check_reset_state();
      rst_n_i = 1'b1;
      drive_inputs();
      for (int c = 0; c < N_CYCLES; c++) begin
         @(negedge wb_clk);
         check_outputs();   // outputs settled since the rising edge
         drive_inputs();
      end
      $display("checks: %0d  errors: %0d", n_checks, n_err);
      if (n_err == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // watchdog over the whole run length plus margin
   initial begin
      #((RST_CYCLES + N_CYCLES + MARGIN) * CLK_PERIOD);
      $display("watchdog expired before the test sequence completed");
      $display("Test FAILED");
      $finish;
   end

endmodule

//--- mc1201_fabric.f
+incdir+tb
src/mc1201_pkg.sv
src/wb_bus_if.sv
src/bus_master_switch.sv
src/io_page_decoder.sv
src/sd_card_dispatcher.sv
src/board_ctrl.sv
src/mc1201_fabric.sv
tb/tb_mc1201_fabric.sv

//--- Makefile
# Verilator flow for the mc1201 bus fabric
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FLIST     ?= mc1201_fabric.f
RTL_TOP   ?= mc1201_fabric
TB_TOP    ?= tb_mc1201_fabric
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SIM_EXE := $(OBJ_DIR)/V$(TB_TOP)
SOURCES := $(FLIST) $(wildcard src/*.sv tb/*.sv tb/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(SIM_EXE): $(SOURCES)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(SIM_EXE)
	./$(SIM_EXE) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
